// ==== build.f ====
hw/radio_pkg.sv
hw/gpio_pkg.sv
hw/fp_gpio_mux.sv
hw/slot_io.sv
hw/radio_glue_top.sv
bench/radio_glue_assertions.sv
bench/tb_radio_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator compile and run of the radio glue testbench, from the project root

top=tb_radio_glue
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$top" -f build.f -o "$top"
if [ $? -ne 0 ]; then
   echo "FAIL: Verilator compile step returned an error"
   exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
   echo "FAIL: testbench reported a failure, see $log"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "FAIL: simulation exited with status $run_status"
   exit 1
fi

echo "PASS: no failure found in $log"
exit 0

// ==== bench/tb_radio_glue.sv ====
/* testbench for the two-slot radio glue
   table-driven stimulus, typed compare tasks and a watchdog */
`timescale 1ns/1ns

module tb_radio_glue
   import radio_pkg::*, gpio_pkg::*;
;

   localparam int NUM_ROWS        = 8;
   localparam int DRIVE_DLY       = 1;                        // ns after the rising edge
   localparam int WATCHDOG_CYCLES = 16 + 6 * NUM_ROWS + 50;

   // one table row, inputs first and the expected responses after them
   typedef struct packed {
      fp_src_t                    src;
      fp_drive_t  [1:0]           slot_fp;
      fp_drive_t                  user_fp;
      sample_t    [1:0]           rx;
      chan_pair_t [1:0]           tx_chan;
      chan_run_t  [1:0][1:0]      run;                        // [slot][channel]
      misc_word_t [1:0]           misc_in;
      misc_word_t [1:0]           misc_to_pins;
      misc_word_t [1:0]           leds;
      fp_drive_t                  exp_fp;
      sample_t    [1:0]           exp_tx;
      chan_pair_t [1:0]           exp_rx;
      slot_run_t  [1:0]           exp_run;
      led_field_t [1:0]           exp_led;
   } row_t;

   logic       radio_clk;
   logic       i_rst_n;
   fp_src_t    i_fp_src;
   fp_drive_t  i_slot_fp      [NUM_SLOTS];
   fp_drive_t  i_user_fp;
   fp_drive_t  o_fp;
   sample_t    i_rx           [NUM_SLOTS];
   chan_pair_t i_tx_chan      [NUM_SLOTS];
   chan_run_t  i_chan_run     [NUM_SLOTS][CHANS_PER_SLOT];
   misc_word_t i_misc_in      [NUM_SLOTS];
   misc_word_t i_misc_to_pins [NUM_SLOTS];
   misc_word_t i_leds         [NUM_SLOTS];
   sample_t    o_tx           [NUM_SLOTS];
   chan_pair_t o_rx_chan      [NUM_SLOTS];
   slot_run_t  o_run          [NUM_SLOTS];
   misc_word_t o_misc_in      [NUM_SLOTS];
   misc_word_t o_misc_out     [NUM_SLOTS];
   led_field_t o_led          [NUM_SLOTS];

   row_t   rows [NUM_ROWS];
   integer seed = 32'hd37d_b37a;
   int     assert_fails;

   radio_glue_top #(
      .SYNC_STAGES (2)
   ) u_radio_glue_top (
      .radio_clk (radio_clk), .i_rst_n (i_rst_n),
      .i_fp_src (i_fp_src), .i_slot_fp (i_slot_fp), .i_user_fp (i_user_fp), .o_fp (o_fp),
      .i_rx (i_rx), .i_tx_chan (i_tx_chan), .i_chan_run (i_chan_run),
      .i_misc_in (i_misc_in), .i_misc_to_pins (i_misc_to_pins), .i_leds (i_leds),
      .o_tx (o_tx), .o_rx_chan (o_rx_chan), .o_run (o_run),
      .o_misc_in (o_misc_in), .o_misc_out (o_misc_out), .o_led (o_led)
   );

   initial begin
      radio_clk = 1'b0;
      forever #5 radio_clk = ~radio_clk;                      // 10 ns period
   end

   // --------------------------------------------------------------------------
   // helpers
   // --------------------------------------------------------------------------
   function automatic logic [31:0] draw_word();
      draw_word = $random(seed);
   endfunction

   // reference pin mux: user_sel wins, else slot_sel names the ATR slot
   function automatic fp_drive_t expected_pins(fp_src_t src, fp_drive_t s0, fp_drive_t s1,
                                               fp_drive_t usr);
      fp_drive_t res;
      for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
         if (src[p].user_sel) begin
            res.out[p] = usr.out[p];
            res.ddr[p] = usr.ddr[p];
         end else if (src[p].slot_sel) begin
            res.out[p] = s1.out[p];
            res.ddr[p] = s1.ddr[p];
         end else begin
            res.out[p] = s0.out[p];
            res.ddr[p] = s0.ddr[p];
         end
      end
      return res;
   endfunction

   task automatic stop_on_error();
      $display("sim failed");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic check_fp(input string name, input fp_drive_t got, input fp_drive_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_pair(input string name, input chan_pair_t got, input chan_pair_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_run(input string name, input slot_run_t got, input slot_run_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_misc(input string name, input misc_word_t got, input misc_word_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_led(input string name, input led_field_t got, input led_field_t exp);
      if (got !== exp) begin
         $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   // --------------------------------------------------------------------------
   // stimulus table
   // --------------------------------------------------------------------------
   task automatic fill_table();
      logic [31:0] rnd;
      fp_drive_t   shared_user;
      rnd = draw_word();
      shared_user = rnd[23:0];                                // user drive held over rows 4..6
      for (int r = 0; r < NUM_ROWS; r++) begin
         rnd = draw_word();
         case (r)
            0:       rows[r].src = 24'h000000;                // every pin on slot 0
            1:       rows[r].src = 24'h555555;                // every pin on slot 1
            2:       rows[r].src = 24'h451041;                // slot mixed per pin
            3:       rows[r].src = 24'h9e27d8;                // user and slot mixed
            4, 6:    rows[r].src = 24'haaaaaa;                // all user, slot_sel 0
            5:       rows[r].src = 24'hffffff;                // all user, slot_sel 1
            default: rows[r].src = rnd[23:0];
         endcase
         rnd = draw_word();
         rows[r].user_fp = (r >= 4 && r <= 6) ? shared_user : rnd[23:0];
         for (int s = 0; s < NUM_SLOTS; s++) begin
            rnd = draw_word();
            rows[r].slot_fp[s] = rnd[23:0];
            rows[r].rx[s] = draw_word();
            rows[r].tx_chan[s] = {draw_word(), draw_word()};
            // all four channel combinations for rx and for tx over rows 0..3
            rows[r].run[s][0] = chan_run_t'{rx: r[0], tx: r[1] ^ s[0]};
            rows[r].run[s][1] = chan_run_t'{rx: r[1], tx: r[0]};
            rows[r].misc_in[s] = draw_word();
            rows[r].misc_to_pins[s] = draw_word();
            rows[r].leds[s] = draw_word();
            rows[r].exp_tx[s] = rows[r].tx_chan[s].ch0;
            rows[r].exp_rx[s] = chan_pair_t'{ch1: rows[r].rx[s], ch0: rows[r].rx[s]};
            rows[r].exp_run[s] = slot_run_t'{
               run_rx: rows[r].run[s][0].rx | rows[r].run[s][1].rx,
               run_tx: rows[r].run[s][0].tx | rows[r].run[s][1].tx};
            rows[r].exp_led[s] = led_field_t'{rx: rows[r].leds[s][2],
               txrx_tx: rows[r].leds[s][1], txrx_rx: rows[r].leds[s][0]};
         end
         rows[r].exp_fp = expected_pins(rows[r].src, rows[r].slot_fp[0],
                                        rows[r].slot_fp[1], rows[r].user_fp);
      end
   endtask

   task automatic apply_row(input int r);
      i_fp_src  = rows[r].src;
      i_user_fp = rows[r].user_fp;
      for (int s = 0; s < NUM_SLOTS; s++) begin
         i_slot_fp[s]      = rows[r].slot_fp[s];
         i_rx[s]           = rows[r].rx[s];
         i_tx_chan[s]      = rows[r].tx_chan[s];
         i_chan_run[s][0]  = rows[r].run[s][0];
         i_chan_run[s][1]  = rows[r].run[s][1];
         i_misc_in[s]      = rows[r].misc_in[s];
         i_misc_to_pins[s] = rows[r].misc_to_pins[s];
         i_leds[s]         = rows[r].leds[s];
      end
   endtask

   task automatic check_row(input int r);
      check_fp("o_fp", o_fp, rows[r].exp_fp);
      for (int s = 0; s < NUM_SLOTS; s++) begin
         check_sample($sformatf("o_tx[%0d]", s), o_tx[s], rows[r].exp_tx[s]);
         check_pair($sformatf("o_rx_chan[%0d]", s), o_rx_chan[s], rows[r].exp_rx[s]);
         check_run($sformatf("o_run[%0d]", s), o_run[s], rows[r].exp_run[s]);
         check_misc($sformatf("o_misc_in[%0d]", s), o_misc_in[s], rows[r].misc_in[s]);
         check_misc($sformatf("o_misc_out[%0d]", s), o_misc_out[s], rows[r].misc_to_pins[s]);
         check_led($sformatf("o_led[%0d]", s), o_led[s], rows[r].exp_led[s]);
      end
   endtask

   // --------------------------------------------------------------------------
   // main sequence
   // --------------------------------------------------------------------------
   initial begin
      i_rst_n = 1'b1;
      fill_table();
      apply_row(NUM_ROWS - 1);                                // busy inputs during reset
      i_fp_src = 24'hffffff;                                  // user on all pins, still 0 out
      #1 i_rst_n = 1'b0;
      repeat (15) @(posedge radio_clk);
      @(negedge radio_clk);
      check_fp("o_fp", o_fp, '0);
      for (int s = 0; s < NUM_SLOTS; s++) begin
         check_misc($sformatf("o_misc_in[%0d]", s), o_misc_in[s], '0);
         check_misc($sformatf("o_misc_out[%0d]", s), o_misc_out[s], '0);
      end
      @(posedge radio_clk);
      #DRIVE_DLY i_rst_n = 1'b1;                              // 16 cycles of reset
      for (int r = 0; r < NUM_ROWS; r++) begin
         @(posedge radio_clk);
         #DRIVE_DLY apply_row(r);
         repeat (4) @(posedge radio_clk);                     // sync, atr stage, misc flop
         @(negedge radio_clk);
         check_row(r);
      end
      assert_fails = u_radio_glue_top.u_fp_gpio_mux.u_fp_checks.fail_count
                   + u_radio_glue_top.u_slot_io_0.u_slot_checks.fail_count
                   + u_radio_glue_top.u_slot_io_1.u_slot_checks.fail_count;
      if (assert_fails == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         $display("%0d bound assertions failed during the run", assert_fails);
         $display("sim failed");
         $fatal(1, "assertion failures");
      end
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge radio_clk);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== bench/radio_glue_assertions.sv ====
/* concurrent checks bound into the radio glue
   watched words clear in reset, o_fp steady while user drive owns every pin */
`timescale 1ns/1ns

module radio_glue_assertions #(
   parameter int WORD_W     = 24,
   parameter int TRIG_W     = 48,
   parameter int KEEP_W     = 24,
   parameter bit HOLD_CHECK = 1'b1          // pin hold check, fp mux only
) (
   input logic              radio_clk,
   input logic              i_rst_n,
   input logic [WORD_W-1:0] i_word,         // outputs under watch
   input logic [TRIG_W-1:0] i_trig,         // slot drive
   input logic [KEEP_W-1:0] i_keep,         // user drive
   input logic              i_hold_en       // synced select has user on every pin
);

   int fail_count = 0;

   // registered outputs sit at 0 for the whole reset
   reset_clear: assert property (@(posedge radio_clk) !i_rst_n |-> (i_word == '0))
      else begin
         fail_count++;
         $error("watched word not 0 while reset is active");
      end

   // slot drive moved a cycle ago, user drive did not, so the pins hold
   generate
      if (HOLD_CHECK) begin : g_hold
         user_hold: assert property (@(posedge radio_clk) disable iff (!i_rst_n)
            (i_hold_en && $past(i_hold_en) && ($past(i_trig) != $past(i_trig, 2))
             && $stable(i_keep)) |-> $stable(i_word))
            else begin
               fail_count++;
               $error("o_fp moved after a slot drive change with all pins on user drive");
            end
      end
   endgenerate

endmodule

bind fp_gpio_mux radio_glue_assertions #(.WORD_W(24), .TRIG_W(48), .KEEP_W(24)) u_fp_checks (
   .radio_clk (radio_clk), .i_rst_n (i_rst_n), .i_word (o_fp),
   .i_trig ({i_slot_fp[0], i_slot_fp[1]}), .i_keep (i_user_fp),
   .i_hold_en ((src_s & 24'haaaaaa) == 24'haaaaaa)
);

bind slot_io radio_glue_assertions #(.WORD_W(64), .HOLD_CHECK(1'b0)) u_slot_checks (
   .radio_clk (radio_clk), .i_rst_n (i_rst_n), .i_word ({o_misc_in, o_misc_out}),
   .i_trig (), .i_keep (), .i_hold_en ()
);

// ==== hw/radio_glue_top.sv ====
/* radio-clock glue top for two daughterboard slots
   front-panel GPIO mux plus one slot_io block per slot */
`timescale 1ns/1ns

module radio_glue_top
   import radio_pkg::*, gpio_pkg::*;
#(
   parameter int SYNC_STAGES = 2                     // fp source synchroniser depth
) (
   input  logic       radio_clk,
   input  logic       i_rst_n,
   // front-panel GPIO
   input  fp_src_t    i_fp_src,                      // per-pin source select
   input  fp_drive_t  i_slot_fp [NUM_SLOTS],         // ATR drive per slot
   input  fp_drive_t  i_user_fp,                     // user logic drive
   output fp_drive_t  o_fp,
   // slot inputs, indexed by slot
   input  sample_t    i_rx           [NUM_SLOTS],
   input  chan_pair_t i_tx_chan      [NUM_SLOTS],
   input  chan_run_t  i_chan_run     [NUM_SLOTS][CHANS_PER_SLOT],
   input  misc_word_t i_misc_in      [NUM_SLOTS],
   input  misc_word_t i_misc_to_pins [NUM_SLOTS],
   input  misc_word_t i_leds         [NUM_SLOTS],
   // slot outputs, indexed by slot
   output sample_t    o_tx           [NUM_SLOTS],
   output chan_pair_t o_rx_chan      [NUM_SLOTS],
   output slot_run_t  o_run          [NUM_SLOTS],
   output misc_word_t o_misc_in      [NUM_SLOTS],
   output misc_word_t o_misc_out     [NUM_SLOTS],
   output led_field_t o_led          [NUM_SLOTS]
);

   // -------------------------------------------------------------------------
   // front-panel GPIO source mux
   // -------------------------------------------------------------------------
   fp_gpio_mux #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_fp_gpio_mux (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_fp_src   (i_fp_src),
      .i_slot_fp  (i_slot_fp),
      .i_user_fp  (i_user_fp),
      .o_fp       (o_fp)
   );

   // -------------------------------------------------------------------------
   // slots
   // -------------------------------------------------------------------------
   slot_io u_slot_io_0 (                             // RFA
      .radio_clk      (radio_clk),
      .i_rst_n        (i_rst_n),
      .i_rx           (i_rx[0]),
      .i_tx_chan      (i_tx_chan[0]),
      .i_chan_run     (i_chan_run[0]),
      .i_misc_in      (i_misc_in[0]),
      .i_misc_to_pins (i_misc_to_pins[0]),
      .i_leds         (i_leds[0]),
      .o_tx           (o_tx[0]),
      .o_rx_chan      (o_rx_chan[0]),
      .o_run          (o_run[0]),
      .o_misc_in      (o_misc_in[0]),
      .o_misc_out     (o_misc_out[0]),
      .o_led          (o_led[0])
   );

   slot_io u_slot_io_1 (                             // RFB
      .radio_clk      (radio_clk),
      .i_rst_n        (i_rst_n),
      .i_rx           (i_rx[1]),
      .i_tx_chan      (i_tx_chan[1]),
      .i_chan_run     (i_chan_run[1]),
      .i_misc_in      (i_misc_in[1]),
      .i_misc_to_pins (i_misc_to_pins[1]),
      .i_leds         (i_leds[1]),
      .o_tx           (o_tx[1]),
      .o_rx_chan      (o_rx_chan[1]),
      .o_run          (o_run[1]),
      .o_misc_in      (o_misc_in[1]),
      .o_misc_out     (o_misc_out[1]),
      .o_led          (o_led[1])
   );

endmodule

// ==== hw/slot_io.sv ====
/* per-slot radio glue
   rx duplication, tx pick, ATR run OR, misc registers and LED field */
`timescale 1ns/1ns

module slot_io
   import radio_pkg::*;
(
   input  logic       radio_clk,
   input  logic       i_rst_n,
   input  sample_t    i_rx,                          // ADC word of this slot
   input  chan_pair_t i_tx_chan,                     // tx samples of both channels
   input  chan_run_t  i_chan_run [CHANS_PER_SLOT],   // running flags per channel
   input  misc_word_t i_misc_in,                     // misc pins from the board
   input  misc_word_t i_misc_to_pins,                // misc word toward the board
   input  misc_word_t i_leds,                        // slot LED word
   output sample_t    o_tx,                          // DAC word of this slot
   output chan_pair_t o_rx_chan,                     // rx word per channel
   output slot_run_t  o_run,                         // ATR run flags
   output misc_word_t o_misc_in,                     // registered misc in
   output misc_word_t o_misc_out,                    // registered misc out
   output led_field_t o_led                          // front LEDs of the slot
);

   // -------------------------------------------------------------------------
   // channel mapping
   // -------------------------------------------------------------------------
   // one ADC feeds both channels of the slot
   assign o_rx_chan.ch0 = i_rx;
   assign o_rx_chan.ch1 = i_rx;

   assign o_tx = i_tx_chan.ch0;           // only channel 0 reaches the DAC

   // -------------------------------------------------------------------------
   // run indication
   // -------------------------------------------------------------------------
   // ATR cannot tell channels apart, any running channel counts
   always_comb begin
      o_run = '0;
      for (int c = 0; c < CHANS_PER_SLOT; c++) begin
         o_run.run_rx = o_run.run_rx | i_chan_run[c].rx;
         o_run.run_tx = o_run.run_tx | i_chan_run[c].tx;
      end
   end

   // -------------------------------------------------------------------------
   // misc words
   // -------------------------------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_misc_in  <= '0;
         o_misc_out <= '0;
      end else begin
         o_misc_in  <= i_misc_in;         // board toward control, one flop
         o_misc_out <= i_misc_to_pins;    // control toward board, one flop
      end
   end

   // -------------------------------------------------------------------------
   // LEDs
   // -------------------------------------------------------------------------
   // low three bits are rx, txrx_tx, txrx_rx from msb down
   assign o_led = led_field_t'(i_leds[2:0]);

endmodule

// ==== hw/fp_gpio_mux.sv ====
/* front-panel GPIO source mux
   syncs the per-pin source word into radio_clk, then per pin picks
   slot 0 or slot 1 ATR drive (registered) and finally slot or user drive */
`timescale 1ns/1ns

module fp_gpio_mux
   import gpio_pkg::*;
#(
   parameter int SYNC_STAGES = 2          // synchroniser depth, 2 or more
) (
   input  logic      radio_clk,
   input  logic      i_rst_n,
   input  fp_src_t   i_fp_src,            // from the control domain, async here
   input  fp_drive_t i_slot_fp [2],       // ATR drive, indexed by slot
   input  fp_drive_t i_user_fp,           // user logic drive
   output fp_drive_t o_fp                 // to the pin drivers
);

   // -------------------------------------------------------------------------
   // source word synchroniser
   // -------------------------------------------------------------------------
   fp_src_t [SYNC_STAGES-1:0] src_sync_q; // [0] is the capture flop
   fp_src_t                   src_s;      // synced select word

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         src_sync_q <= '0;
      end else begin
         src_sync_q <= {src_sync_q[SYNC_STAGES-2:0], i_fp_src};   // shift in
      end
   end

   assign src_s = src_sync_q[SYNC_STAGES-1];   // last stage only

   // -------------------------------------------------------------------------
   // first stage, slot ATR select
   // -------------------------------------------------------------------------
   fp_drive_t atr_q;                      // registered slot drive per pin

   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         atr_q <= '0;
      end else begin
         for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
            // each pin takes its bit from the slot it names
            atr_q.out[p] <= i_slot_fp[src_s[p].slot_sel].out[p];
            atr_q.ddr[p] <= i_slot_fp[src_s[p].slot_sel].ddr[p];
         end
      end
   end

   // -------------------------------------------------------------------------
   // second stage, slot or user drive
   // -------------------------------------------------------------------------
   // plain select, user path has no register so user drive is seen
   // on the pins in the same cycle
   always_comb begin
      for (int p = 0; p < FP_GPIO_WIDTH; p++) begin
         if (src_s[p].user_sel) begin
            o_fp.out[p] = i_user_fp.out[p];   // user logic owns the pin
            o_fp.ddr[p] = i_user_fp.ddr[p];
         end else begin
            o_fp.out[p] = atr_q.out[p];       // ATR from selected slot
            o_fp.ddr[p] = atr_q.ddr[p];
         end
      end
   end

   // after reset both select bits are 0 and atr_q is clear
   // so every pin reads 0 until user drive is picked

endmodule

// ==== hw/gpio_pkg.sv ====
/* front-panel GPIO types
   pin vector, out/ddr drive pair and the per-pin source select word */
package gpio_pkg;

   // -------------------------------------------------------------------------
   // pin count and vectors
   // -------------------------------------------------------------------------
   localparam int FP_GPIO_WIDTH = 12;     // pins on the front-panel header

   typedef logic [FP_GPIO_WIDTH-1:0] fp_pins_t;   // one bit per pin

   // drive for all pins, ddr high means pin is an output
   typedef struct packed {
      fp_pins_t out;                      // upper 12 bits
      fp_pins_t ddr;                      // lower 12 bits
   } fp_drive_t;

   // -------------------------------------------------------------------------
   // source select
   // -------------------------------------------------------------------------
   // 2'b00 slot 0 ATR, 2'b01 slot 1 ATR, 2'b1x user logic
   typedef struct packed {
      logic user_sel;                     // bit 2i+1 of the source word
      logic slot_sel;                     // bit 2i
   } pin_src_t;

   // whole source word, pin i in bits 2i and 2i+1
   typedef pin_src_t [FP_GPIO_WIDTH-1:0] fp_src_t;

   // 24 bits in total, same width as fp_drive_t
   // slot_sel picks which daughterboard ATR drives the pin
   // user_sel overrides the slot choice for that pin

endpackage

// ==== hw/radio_pkg.sv ====
/* radio slot types for the two-slot radio glue
   sample words, channel pairing, run flags, misc and LED fields */
package radio_pkg;

   // -------------------------------------------------------------------------
   // counts
   // -------------------------------------------------------------------------
   localparam int NUM_SLOTS      = 2;     // slot select on the fp mux is one bit
   localparam int CHANS_PER_SLOT = 2;     // channels served by one daughterboard

   // -------------------------------------------------------------------------
   // data words
   // -------------------------------------------------------------------------
   typedef logic [31:0] sample_t;         // one radio sample, i/q packed
   typedef logic [31:0] misc_word_t;      // misc word to or from a slot

   // both channels of one slot, ch0 sits in the low half
   typedef struct packed {
      sample_t ch1;
      sample_t ch0;
   } chan_pair_t;

   // running flags of a single channel
   typedef struct packed {
      logic rx;                           // rx chain streaming
      logic tx;                           // tx chain streaming
   } chan_run_t;

   // ATR run indication for a whole slot
   typedef struct packed {
      logic run_rx;
      logic run_tx;
   } slot_run_t;

   typedef struct packed {
      logic rx;                           // rx led, bit 2
      logic txrx_tx;                      // tx/rx port transmitting
      logic txrx_rx;                      // tx/rx port receiving, bit 0
   } led_field_t;

endpackage
